//--- vlog.f
+incdir+include
+incdir+tb
design/memop_pkg.sv
design/dcache_pkg.sv
design/stage_reg.sv
design/core_port.sv
design/dcache_lookup.sv
design/dcache_miss.sv
design/main_memory.sv
design/dmem_top.sv
tb/dmem_tb.sv

//--- Makefile
SOURCES := vlog.f $(wildcard include/*.svh design/*.sv tb/*.sv tb/*.svh)

.PHONY: run clean

run: obj_dir/Vdmem_tb
	obj_dir/Vdmem_tb | tee sim.log
	! grep -q "tests failed" sim.log
	grep -q "all tests passed" sim.log

# rebuilt only when a source or the file list changes
obj_dir/Vdmem_tb: $(SOURCES)
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module dmem_tb -o Vdmem_tb

clean:
	rm -rf obj_dir sim.log

//--- tb/dmem_tests.svh
`ifndef DMEM_TESTS_SVH
`define DMEM_TESTS_SVH

task automatic test_reset_state();
    start_test("reset_state");
    check_word(`WORD_SIZE'(core_ack_o), '0, WORD, "ack right after reset");
    load_check(32'h100, WORD, 1'b0); // untouched memory reads zero
    load_check(32'h7fc, WORD, 1'b0);
    finish_test();
endtask

task automatic test_store_load_sizes();
    logic [31:0] rdata;
    int cycles;
    start_test("store_load_sizes");
    store_value(32'h040, WORD, 32'h11223344);
    load_value(32'h040, BYTE, 1'b1, rdata, cycles);
    check_word(rdata, 32'h00000044, BYTE, "lowest byte of stored word");
    load_check(32'h041, BYTE, 1'b1);
    load_check(32'h042, HALF, 1'b1);
    load_check(32'h040, WORD, 1'b0);
    store_value(32'h046, HALF, 32'h0000beef); // line is cached now
    store_value(32'h045, BYTE, 32'h0000005a);
    load_value(32'h044, WORD, 1'b0, rdata, cycles);
    check_word(rdata, 32'hbeef5a00, WORD, "word built from half and byte");
    load_check(32'h044, WORD, 1'b0);
    finish_test();
endtask

task automatic test_sign_extension();
    logic [31:0] rdata;
    int cycles;
    start_test("sign_extension");
    store_value(32'h080, WORD, 32'h80ff7f80);
    load_value(32'h080, BYTE, 1'b0, rdata, cycles);
    check_word(rdata, 32'hffffff80, BYTE, "signed byte 0x80");
    load_value(32'h080, BYTE, 1'b1, rdata, cycles);
    check_word(rdata, 32'h00000080, BYTE, "unsigned byte 0x80");
    load_value(32'h081, BYTE, 1'b0, rdata, cycles);
    check_word(rdata, 32'h0000007f, BYTE, "signed byte 0x7f");
    load_value(32'h082, HALF, 1'b0, rdata, cycles);
    check_word(rdata, 32'hffff80ff, HALF, "signed half 0x80ff");
    load_value(32'h082, HALF, 1'b1, rdata, cycles);
    check_word(rdata, 32'h000080ff, HALF, "unsigned half 0x80ff");
    load_value(32'h080, HALF, 1'b0, rdata, cycles);
    check_word(rdata, 32'h00007f80, HALF, "signed half 0x7f80");
    finish_test();
endtask

task automatic test_store_hit_evict();
    start_test("store_hit_evict");
    load_check(32'h0c0, WORD, 1'b0); // brings the line in
    store_value(32'h0c4, WORD, 32'hcafef00d);
    load_check(32'h0c4, WORD, 1'b0); // merged copy in the cache
    store_value(32'h0c9, BYTE, 32'h000000a5);
    load_check(32'h0c8, WORD, 1'b0);
    load_check(32'h1c0, WORD, 1'b0); // same index, other tag
    load_check(32'h0c4, WORD, 1'b0); // refetched from memory
    load_check(32'h0c8, WORD, 1'b0);
    finish_test();
endtask

task automatic test_hit_latency();
    logic [31:0] rdata;
    int miss_cycles;
    int hit_cycles;
    start_test("hit_latency");
    load_value(32'h200, WORD, 1'b0, rdata, miss_cycles);
    check_word(rdata, expected_load(32'h200, WORD, 1'b0), WORD, "first load of line");
    check_latency(miss_cycles, `MEM_LATENCY, `MEM_LATENCY + 20, "line fill");
    load_value(32'h20c, WORD, 1'b0, rdata, hit_cycles);
    check_word(rdata, expected_load(32'h20c, WORD, 1'b0), WORD, "second load of line");
    check_latency(hit_cycles, 1, 3, "cache hit");
    finish_test();
endtask

task automatic test_random_mix();
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] data;
    memop_data_type_e dtype;
    start_test("random_mix");
    for (int i = 0; i < 200; i++) begin
        r = next_random();
        data = next_random();
        case (r[1:0])
            2'd0:    dtype = BYTE;
            2'd1:    dtype = HALF;
            default: dtype = WORD;
        endcase
        addr = {23'b0, r[12:4]}; // 512 byte window
        if (dtype == WORD) begin
            addr[1:0] = 2'b00;
        end else if (dtype == HALF) begin
            addr[0] = 1'b0;
        end
        if (r[2]) begin
            store_value(addr, dtype, data);
        end else begin
            load_check(addr, dtype, r[3]);
        end
    end
    finish_test();
endtask

`endif

//--- tb/dmem_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "dmem_macros.svh"

module dmem_tb import memop_pkg::*, dcache_pkg::*; ();

    localparam int ACCESS_COUNT = 230; // directed accesses plus the random mix
    localparam int TIMEOUT_CYCLES = ACCESS_COUNT * (`MEM_LATENCY + 20) + 100;

    logic                  clk_i;
    logic                  rst_i;
    logic                  core_req_i;
    memop_kind_e           core_kind_i;
    memop_data_type_e      core_type_i;
    logic                  core_unsigned_i;
    logic [`WORD_SIZE-1:0] core_addr_i;
    logic [`WORD_SIZE-1:0] core_wdata_i;
    logic                  core_ack_o;
    logic [`WORD_SIZE-1:0] core_rdata_o;

    logic [7:0] shadow_mem [`MEM_BYTES]; // reference copy of main memory
    logic [31:0] rng_state;
    int cycle_count;
    int error_count;
    int check_count;
    int test_count;
    int test_first_error;
    string test_name;

    dmem_top dut (
        .clk_i(clk_i), .rst_i(rst_i),
        .core_req_i(core_req_i), .core_kind_i(core_kind_i), .core_type_i(core_type_i),
        .core_unsigned_i(core_unsigned_i), .core_addr_i(core_addr_i),
        .core_wdata_i(core_wdata_i), .core_ack_o(core_ack_o), .core_rdata_o(core_rdata_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("run timed out after %0d cycles waiting for ack", cycle_count);
        $display("tests failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int bytes_of(input memop_data_type_e dtype);
        case (dtype)
            BYTE:    return 1;
            HALF:    return 2;
            default: return 4;
        endcase
    endfunction

    task automatic shadow_store(input logic [31:0] addr, input memop_data_type_e dtype,
                                input logic [31:0] data);
        for (int k = 0; k < bytes_of(dtype); k++) begin
            shadow_mem[(int'(addr) + k) % `MEM_BYTES] = data[8*k +: 8];
        end
    endtask

    // little endian gather, then fill the upper bits from the top bit when signed
    function automatic logic [31:0] expected_load(input logic [31:0] addr,
                                                  input memop_data_type_e dtype,
                                                  input logic uns);
        logic [31:0] raw;
        int nbytes;
        nbytes = bytes_of(dtype);
        raw = '0;
        for (int k = 0; k < nbytes; k++) begin
            raw[8*k +: 8] = shadow_mem[(int'(addr) + k) % `MEM_BYTES];
        end
        if (!uns && raw[8*nbytes-1]) begin
            for (int b = 8 * nbytes; b < 32; b++) begin
                raw[b] = 1'b1;
            end
        end
        return raw;
    endfunction

    task automatic check_word(input logic [`WORD_SIZE-1:0] got, input logic [`WORD_SIZE-1:0] exp,
                              input memop_data_type_e dtype, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail at %0t: %s %s got 0x%08h expected 0x%08h",
                     $time, dtype.name(), what, got, exp);
        end
    endtask

    task automatic check_latency(input int cycles, input int lo, input int hi, input string what);
        check_count++;
        if (cycles < lo || cycles > hi) begin
            error_count++;
            $display("Fail at %0t: %s took %0d cycles, expected %0d to %0d",
                     $time, what, cycles, lo, hi);
        end
    endtask

    // one four-phase access, cycles counts from the edge that first samples req
    task automatic core_access(input memop_kind_e kind, input memop_data_type_e dtype,
                               input logic uns, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output int cycles);
        @(negedge clk_i);
        core_kind_i = kind;
        core_type_i = dtype;
        core_unsigned_i = uns;
        core_addr_i = addr;
        core_wdata_i = wdata;
        core_req_i = 1'b1;
        cycles = 0;
        @(negedge clk_i);
        while (!core_ack_o) begin
            cycles++;
            @(negedge clk_i);
        end
        rdata = core_rdata_o;
        core_req_i = 1'b0;
        @(negedge clk_i);
        while (core_ack_o) begin
            @(negedge clk_i);
        end
    endtask

    task automatic store_value(input logic [31:0] addr, input memop_data_type_e dtype,
                               input logic [31:0] data);
        logic [31:0] rdata;
        int cycles;
        core_access(STORE, dtype, 1'b0, addr, data, rdata, cycles);
        shadow_store(addr, dtype, data);
        check_word(rdata, '0, dtype, $sformatf("store 0x%03h read data", addr));
    endtask

    task automatic load_value(input logic [31:0] addr, input memop_data_type_e dtype,
                              input logic uns, output logic [31:0] rdata, output int cycles);
        core_access(LOAD, dtype, uns, addr, '0, rdata, cycles);
    endtask

    task automatic load_check(input logic [31:0] addr, input memop_data_type_e dtype,
                              input logic uns);
        logic [31:0] rdata;
        int cycles;
        load_value(addr, dtype, uns, rdata, cycles);
        check_word(rdata, expected_load(addr, dtype, uns), dtype,
                   $sformatf("load 0x%03h unsigned=%0b", addr, uns));
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_first_error = error_count;
        test_count++;
    endtask

    task automatic finish_test();
        if (error_count == test_first_error) begin
            $display("test %s done, no errors", test_name);
        end else begin
            $display("test %s done, %0d errors", test_name, error_count - test_first_error);
        end
    endtask

    `include "dmem_tests.svh"

    initial begin
        rst_i = 1'b1;
        core_req_i = 1'b0;
        core_kind_i = LOAD;
        core_type_i = WORD;
        core_unsigned_i = 1'b0;
        core_addr_i = '0;
        core_wdata_i = '0;
        rng_state = 32'hda88;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        for (int i = 0; i < `MEM_BYTES; i++) begin
            shadow_mem[i] = 8'h00;
        end
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        test_reset_state();
        test_store_load_sizes();
        test_sign_extension();
        test_store_hit_evict();
        test_hit_latency();
        test_random_mix();

        $display("summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/dmem_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "dmem_macros.svh"

module dmem_top import memop_pkg::*, dcache_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  core_req_i,
    input  memop_kind_e           core_kind_i,
    input  memop_data_type_e      core_type_i,
    input  logic                  core_unsigned_i,
    input  logic [`WORD_SIZE-1:0] core_addr_i,
    input  logic [`WORD_SIZE-1:0] core_wdata_i,
    output logic                  core_ack_o,
    output logic [`WORD_SIZE-1:0] core_rdata_o
);

    logic a_in_valid, a_in_ready, a_out_valid, a_out_ready;
    lookup_req_t a_in_data, a_out_data;
    logic b_in_valid, b_in_ready, b_out_valid, b_out_ready;
    mem_op_t b_in_data, b_out_data;

    logic hit, fill_we, fill_done, store_done;
    line_t hit_line, fill_line;
    index_t fill_index;
    tag_t fill_tag;

    logic mem_req, mem_we, mem_ack;
    memop_data_type_e mem_type;
    logic [`WORD_SIZE-1:0] mem_addr, mem_wdata;
    line_t mem_rdata;

    core_port u_core_port (
        .clk_i(clk_i), .rst_i(rst_i),
        .core_req_i(core_req_i), .core_kind_i(core_kind_i), .core_type_i(core_type_i),
        .core_unsigned_i(core_unsigned_i), .core_addr_i(core_addr_i),
        .core_wdata_i(core_wdata_i), .core_ack_o(core_ack_o), .core_rdata_o(core_rdata_o),
        .req_valid_o(a_in_valid), .req_data_o(a_in_data), .req_ready_i(a_in_ready),
        .hit_i(hit), .hit_line_i(hit_line),
        .fill_done_i(fill_done), .fill_line_i(fill_line), .store_done_i(store_done)
    );

    stage_reg #(.payload_t(lookup_req_t)) u_stage_a (
        .clk_i(clk_i), .rst_i(rst_i),
        .valid_i(a_in_valid), .ready_o(a_in_ready), .data_i(a_in_data),
        .valid_o(a_out_valid), .ready_i(a_out_ready), .data_o(a_out_data)
    );

    dcache_lookup u_lookup (
        .clk_i(clk_i), .rst_i(rst_i),
        .in_valid_i(a_out_valid), .in_data_i(a_out_data), .in_ready_o(a_out_ready),
        .hit_o(hit), .hit_line_o(hit_line),
        .out_valid_o(b_in_valid), .out_data_o(b_in_data), .out_ready_i(b_in_ready),
        .fill_we_i(fill_we), .fill_index_i(fill_index), .fill_tag_i(fill_tag),
        .fill_line_i(fill_line)
    );

    stage_reg #(.payload_t(mem_op_t)) u_stage_b (
        .clk_i(clk_i), .rst_i(rst_i),
        .valid_i(b_in_valid), .ready_o(b_in_ready), .data_i(b_in_data),
        .valid_o(b_out_valid), .ready_i(b_out_ready), .data_o(b_out_data)
    );

    dcache_miss u_miss (
        .clk_i(clk_i), .rst_i(rst_i),
        .in_valid_i(b_out_valid), .in_data_i(b_out_data), .in_ready_o(b_out_ready),
        .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_type_o(mem_type),
        .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
        .mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata),
        .fill_we_o(fill_we), .fill_index_o(fill_index), .fill_tag_o(fill_tag),
        .fill_line_o(fill_line), .fill_done_o(fill_done), .store_done_o(store_done)
    );

    main_memory u_memory (
        .clk_i(clk_i), .rst_i(rst_i),
        .req_i(mem_req), .we_i(mem_we), .type_i(mem_type),
        .addr_i(mem_addr), .wdata_i(mem_wdata),
        .ack_o(mem_ack), .rdata_o(mem_rdata)
    );

endmodule

`default_nettype wire

//--- design/main_memory.sv
`timescale 1ns/100ps
`default_nettype none

`include "dmem_macros.svh"

module main_memory import memop_pkg::*, dcache_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  req_i,
    input  logic                  we_i,
    input  memop_data_type_e      type_i,
    input  logic [`WORD_SIZE-1:0] addr_i,
    input  logic [`WORD_SIZE-1:0] wdata_i,
    output logic                  ack_o,
    output line_t                 rdata_o
);

    localparam int MEM_AW = $clog2(`MEM_BYTES);
    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_BUSY,
        MEM_ACK
    } mem_state_e;

    mem_state_e state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [7:0] mem_q [`MEM_BYTES];

    logic [`WORD_SIZE-1:0] aligned_addr;
    logic [MEM_AW-1:0] byte_addr;
    logic [MEM_AW-1:0] line_base;
    logic [`WORD_SIZE/8-1:0] wr_mask;
    logic access;

    assign aligned_addr = line_addr(addr_i);
    assign byte_addr = addr_i[MEM_AW-1:0]; // wraps at MEM_BYTES
    assign line_base = aligned_addr[MEM_AW-1:0];
    assign wr_mask = memop_byte_mask(type_i);
    assign access = state_q == MEM_BUSY && cnt_q == '0;

    initial begin
        for (int i = 0; i < `MEM_BYTES; i++) begin
            mem_q[i] = 8'h00;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= MEM_IDLE;
            cnt_q <= '0;
            ack_o <= 1'b0;
        end else begin
            case (state_q)
                MEM_IDLE: if (req_i) begin
                    cnt_q <= CNT_W'(`MEM_LATENCY - 1);
                    state_q <= MEM_BUSY;
                end
                MEM_BUSY: if (cnt_q == '0) begin
                    ack_o <= 1'b1;
                    state_q <= MEM_ACK;
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
                default: if (!req_i) begin
                    ack_o <= 1'b0;
                    state_q <= MEM_IDLE;
                end
            endcase
        end
    end

    // little endian, lowest address in the low byte
    always @(posedge clk_i) begin
        if (access && we_i) begin
            for (int k = 0; k < `WORD_SIZE/8; k++) begin
                if (wr_mask[k]) begin
                    mem_q[byte_addr + MEM_AW'(k)] <= wdata_i[8*k +: 8];
                end
            end
        end
        if (access && !we_i) begin
            for (int k = 0; k < `LINE_BYTES; k++) begin
                rdata_o[8*k +: 8] <= mem_q[line_base + MEM_AW'(k)];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/dcache_miss.sv
`timescale 1ns/100ps
`default_nettype none

`include "dmem_macros.svh"

module dcache_miss import memop_pkg::*, dcache_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  in_valid_i,
    input  mem_op_t               in_data_i,
    output logic                  in_ready_o,
    output logic                  mem_req_o,
    output logic                  mem_we_o,
    output memop_data_type_e      mem_type_o,
    output logic [`WORD_SIZE-1:0] mem_addr_o,
    output logic [`WORD_SIZE-1:0] mem_wdata_o,
    input  logic                  mem_ack_i,
    input  line_t                 mem_rdata_i,
    output logic                  fill_we_o,
    output index_t                fill_index_o,
    output tag_t                  fill_tag_o,
    output line_t                 fill_line_o,
    output logic                  fill_done_o,
    output logic                  store_done_o
);

    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_REQ,
        MISS_RELEASE
    } miss_state_e;

    miss_state_e state_q;
    logic is_store;
    logic ack_seen;

    assign in_ready_o = state_q == MISS_IDLE;
    assign is_store = in_data_i.kind == STORE;
    assign ack_seen = state_q == MISS_REQ && mem_ack_i;
    assign fill_done_o = fill_we_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= MISS_IDLE;
            mem_req_o <= 1'b0;
            fill_we_o <= 1'b0;
            store_done_o <= 1'b0;
        end else begin
            fill_we_o <= 1'b0;
            store_done_o <= 1'b0;
            case (state_q)
                MISS_IDLE: if (in_valid_i) begin
                    mem_req_o <= 1'b1;
                    state_q <= MISS_REQ;
                end
                MISS_REQ: if (mem_ack_i) begin
                    mem_req_o <= 1'b0;
                    fill_we_o <= !mem_we_o;
                    store_done_o <= mem_we_o;
                    state_q <= MISS_RELEASE;
                end
                default: if (!mem_ack_i) begin // memory side back to idle
                    state_q <= MISS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_ready_o && in_valid_i) begin
            mem_we_o <= is_store;
            mem_type_o <= in_data_i.dtype;
            mem_addr_o <= is_store ? in_data_i.addr : line_addr(in_data_i.addr);
            mem_wdata_o <= in_data_i.wdata;
        end
        if (ack_seen) begin
            fill_line_o <= mem_rdata_i;
            fill_index_o <= addr_index(mem_addr_o);
            fill_tag_o <= addr_tag(mem_addr_o);
        end
    end

endmodule

`default_nettype wire

//--- design/dcache_lookup.sv
`timescale 1ns/100ps
`default_nettype none

`include "dmem_macros.svh"

module dcache_lookup import memop_pkg::*, dcache_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        in_valid_i,
    input  lookup_req_t in_data_i,
    output logic        in_ready_o,
    output logic        hit_o,
    output line_t       hit_line_o,
    output logic        out_valid_o,
    output mem_op_t     out_data_o,
    input  logic        out_ready_i,
    input  logic        fill_we_i,
    input  index_t      fill_index_i,
    input  tag_t        fill_tag_i,
    input  line_t       fill_line_i
);

    logic [`DCACHE_LINES-1:0] valid_q;
    tag_t tag_q [`DCACHE_LINES];
    line_t data_q [`DCACHE_LINES];

    index_t in_index;
    tag_t in_tag;
    offset_t in_offset;
    logic is_load;
    logic line_hit;
    logic load_hit;
    logic store_hit_wr;
    logic [`LINE_BYTES-1:0] byte_en;
    line_t store_line;
    line_t merged_line;

    assign in_index = addr_index(in_data_i.addr);
    assign in_tag = addr_tag(in_data_i.addr);
    assign in_offset = addr_offset(in_data_i.addr);
    assign is_load = in_data_i.kind == LOAD;
    assign line_hit = valid_q[in_index] && (tag_q[in_index] == in_tag);
    assign load_hit = is_load && line_hit;

    // load hits end here, misses and every store go on to memory
    assign out_valid_o = in_valid_i && !load_hit;
    assign out_data_o = '{kind: in_data_i.kind, dtype: in_data_i.dtype,
                          addr: in_data_i.addr, wdata: in_data_i.wdata};
    assign in_ready_o = load_hit || out_ready_i;

    assign store_hit_wr = in_valid_i && !is_load && line_hit && out_ready_i;

    always_comb begin
        byte_en = `LINE_BYTES'(memop_byte_mask(in_data_i.dtype)) << in_offset;
        store_line = line_t'(in_data_i.wdata) << {in_offset, 3'b000};
        merged_line = data_q[in_index];
        for (int k = 0; k < `LINE_BYTES; k++) begin
            if (byte_en[k]) begin
                merged_line[8*k +: 8] = store_line[8*k +: 8];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
            hit_o <= 1'b0;
        end else begin
            hit_o <= in_valid_i && load_hit;
            if (fill_we_i) begin
                valid_q[fill_index_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        hit_line_o <= data_q[in_index];
        if (store_hit_wr) begin
            data_q[in_index] <= merged_line;
        end
        if (fill_we_i) begin // fill wins over a same-cycle merge
            data_q[fill_index_i] <= fill_line_i;
            tag_q[fill_index_i] <= fill_tag_i;
        end
    end

endmodule

`default_nettype wire

//--- design/core_port.sv
`timescale 1ns/100ps
`default_nettype none

`include "dmem_macros.svh"

module core_port import memop_pkg::*, dcache_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  core_req_i,
    input  memop_kind_e           core_kind_i,
    input  memop_data_type_e      core_type_i,
    input  logic                  core_unsigned_i,
    input  logic [`WORD_SIZE-1:0] core_addr_i,
    input  logic [`WORD_SIZE-1:0] core_wdata_i,
    output logic                  core_ack_o,
    output logic [`WORD_SIZE-1:0] core_rdata_o,
    output logic                  req_valid_o,
    output lookup_req_t           req_data_o,
    input  logic                  req_ready_i,
    input  logic                  hit_i,
    input  line_t                 hit_line_i,
    input  logic                  fill_done_i,
    input  line_t                 fill_line_i,
    input  logic                  store_done_i
);

    typedef enum logic [1:0] {
        CP_IDLE,
        CP_ISSUE,
        CP_WAIT,
        CP_ACK
    } cp_state_e;

    cp_state_e state_q;
    logic resp_any;
    line_t resp_line;
    logic [`WORD_SIZE-1:0] raw_word;
    logic [`WORD_SIZE-1:0] load_value;

    assign resp_any = hit_i || fill_done_i || store_done_i;
    assign resp_line = hit_i ? hit_line_i : fill_line_i;
    assign raw_word = `WORD_SIZE'(resp_line >> {addr_offset(req_data_o.addr), 3'b000});
    assign load_value = memop_extend(req_data_o.dtype, req_data_o.is_unsigned, raw_word);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= CP_IDLE;
            req_valid_o <= 1'b0;
            core_ack_o <= 1'b0;
        end else begin
            case (state_q)
                CP_IDLE: if (core_req_i) begin
                    req_valid_o <= 1'b1;
                    state_q <= CP_ISSUE;
                end
                CP_ISSUE: if (req_ready_i) begin // taken by stage A
                    req_valid_o <= 1'b0;
                    state_q <= CP_WAIT;
                end
                CP_WAIT: if (resp_any) begin
                    core_ack_o <= 1'b1;
                    state_q <= CP_ACK;
                end
                default: if (!core_req_i) begin
                    core_ack_o <= 1'b0;
                    state_q <= CP_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == CP_IDLE && core_req_i) begin
            req_data_o <= '{kind: core_kind_i, dtype: core_type_i,
                            is_unsigned: core_unsigned_i,
                            addr: core_addr_i, wdata: core_wdata_i};
        end
        if (state_q == CP_WAIT && resp_any) begin
            core_rdata_o <= store_done_i ? '0 : load_value; // stores read back zero
        end
    end

endmodule

`default_nettype wire

//--- design/stage_reg.sv
`timescale 1ns/100ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    // room when empty or when the held item leaves this cycle
    assign ready_o = !valid_o || ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else if (ready_o) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ready_o && valid_i) begin
            data_o <= data_i;
        end
    end

endmodule

`default_nettype wire

//--- design/dcache_pkg.sv
`default_nettype none

`include "dmem_macros.svh"

package dcache_pkg;
    import memop_pkg::*;

    localparam int OFFSET_BITS = $clog2(`LINE_BYTES);
    localparam int INDEX_BITS = $clog2(`DCACHE_LINES);
    localparam int TAG_BITS = `WORD_SIZE - INDEX_BITS - OFFSET_BITS;

    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [`DCACHE_LINE_SIZE-1:0] line_t; // byte k at bits 8k+7:8k

    typedef struct packed {
        memop_kind_e kind;
        memop_data_type_e dtype;
        logic is_unsigned;
        logic [`WORD_SIZE-1:0] addr;
        logic [`WORD_SIZE-1:0] wdata;
    } lookup_req_t;

    typedef struct packed {
        memop_kind_e kind;
        memop_data_type_e dtype;
        logic [`WORD_SIZE-1:0] addr;
        logic [`WORD_SIZE-1:0] wdata;
    } mem_op_t;

    function automatic tag_t addr_tag(logic [`WORD_SIZE-1:0] addr);
        return addr[`WORD_SIZE-1 -: TAG_BITS];
    endfunction

    function automatic index_t addr_index(logic [`WORD_SIZE-1:0] addr);
        return addr[OFFSET_BITS +: INDEX_BITS];
    endfunction

    function automatic offset_t addr_offset(logic [`WORD_SIZE-1:0] addr);
        return addr[OFFSET_BITS-1:0];
    endfunction

    function automatic logic [`WORD_SIZE-1:0] line_addr(logic [`WORD_SIZE-1:0] addr);
        return {addr[`WORD_SIZE-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    endfunction

endpackage

`default_nettype wire

//--- design/memop_pkg.sv
`default_nettype none

`include "dmem_macros.svh"

package memop_pkg;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } memop_data_type_e;

    typedef enum logic {
        LOAD,
        STORE
    } memop_kind_e;

    // byte lanes touched by an access, lane 0 at the lowest address
    function automatic logic [`WORD_SIZE/8-1:0] memop_byte_mask(memop_data_type_e dtype);
        logic [`WORD_SIZE/8-1:0] mask;
        case (dtype)
            BYTE:    mask = 4'b0001;
            HALF:    mask = 4'b0011;
            default: mask = 4'b1111;
        endcase
        return mask;
    endfunction

    function automatic logic [`WORD_SIZE-1:0] memop_extend(memop_data_type_e dtype,
                                                           logic is_unsigned,
                                                           logic [`WORD_SIZE-1:0] raw);
        logic [`WORD_SIZE-1:0] res;
        case (dtype)
            BYTE:    res = is_unsigned ? {24'b0, raw[7:0]} : {{24{raw[7]}}, raw[7:0]};
            HALF:    res = is_unsigned ? {16'b0, raw[15:0]} : {{16{raw[15]}}, raw[15:0]};
            default: res = raw;
        endcase
        return res;
    endfunction

endpackage

`default_nettype wire

//--- include/dmem_macros.svh
`ifndef DMEM_MACROS_SVH
`define DMEM_MACROS_SVH

// core data and address width
`define WORD_SIZE 32

// cache line geometry
`define LINE_BYTES 16
`define DCACHE_LINE_SIZE 128
`define DCACHE_LINES 16

// main memory, addresses wrap modulo its size
`define MEM_BYTES 4096
`define MEM_LATENCY 10

`endif
